/* compile.f */
logic/sa_pkg.sv
logic/pe_border.sv
logic/pe_inner.sv
logic/array_8.sv
logic/array_ctrl.sv
logic/sa_top.sv
testbench/sa_checker.sv
testbench/tb_sa_top.sv

/* logic/array_8.sv */
`timescale 1ns/1ps
`default_nettype none

module array_8 #(
    parameter int HEIGHT = sa_pkg::DEF_HEIGHT,
    parameter int WIDTH  = sa_pkg::DEF_WIDTH,
    parameter int IWIDTH = sa_pkg::DEF_IWIDTH,
    parameter int OWIDTH = sa_pkg::DEF_OWIDTH
) (
    input  logic                     clk,
    input  logic                     rst_i,
    input  logic [HEIGHT-1:0]        en_i_i,
    input  logic [HEIGHT-1:0]        clr_i_i,
    input  logic [WIDTH-1:0]         en_w_i,
    input  logic [WIDTH-1:0]         en_o_i,
    input  logic [WIDTH-1:0]         clr_o_i,
    input  logic signed [IWIDTH-1:0] ifm_i  [HEIGHT-1:0],
    input  logic signed [IWIDTH-1:0] wght_i [WIDTH-1:0],
    output logic signed [OWIDTH-1:0] ofm_o  [WIDTH-1:0]
);

    logic [WIDTH:0]           en_i_x  [HEIGHT-1:0];   // Row links, left to right
    logic [WIDTH:0]           clr_i_x [HEIGHT-1:0];
    logic [HEIGHT:0]          en_w_x  [WIDTH-1:0];    // Column links, top to bottom
    logic [HEIGHT:0]          en_o_x  [WIDTH-1:0];    // Column links, bottom to top
    logic [HEIGHT:0]          clr_o_x [WIDTH-1:0];
    logic signed [IWIDTH-1:0] ifm_x   [HEIGHT-1:0][WIDTH:0];
    logic signed [IWIDTH-1:0] wght_x  [WIDTH-1:0][HEIGHT:0];
    logic signed [OWIDTH-1:0] ofm_x   [WIDTH-1:0][HEIGHT:0];

    genvar h;
    genvar w;

    for (h = 0; h < HEIGHT; h++) begin : g_row_edge
        assign en_i_x[h][0]  = en_i_i[h];
        assign clr_i_x[h][0] = clr_i_i[h];
        assign ifm_x[h][0]   = ifm_i[h];
    end

    for (w = 0; w < WIDTH; w++) begin : g_col_edge
        assign en_w_x[w][0]       = en_w_i[w];
        assign wght_x[w][0]       = wght_i[w];
        assign en_o_x[w][HEIGHT]  = en_o_i[w];
        assign clr_o_x[w][HEIGHT] = clr_o_i[w];
        assign ofm_x[w][HEIGHT]   = '0;               // Zero sum enters at the bottom
        assign ofm_o[w]           = ofm_x[w][0];
    end

    for (h = 0; h < HEIGHT; h++) begin : g_row
        pe_border #(
            .ROW_DELAY (h),
            .IWIDTH    (IWIDTH),
            .OWIDTH    (OWIDTH)
        ) u_pe_border (
            .clk     (clk),
            .rst_i   (rst_i),
            .en_i_i  (en_i_x[h][0]),
            .clr_i_i (clr_i_x[h][0]),
            .ifm_i   (ifm_x[h][0]),
            .en_w_i  (en_w_x[0][h]),
            .wght_i  (wght_x[0][h]),
            .en_o_i  (en_o_x[0][h+1]),
            .clr_o_i (clr_o_x[0][h+1]),
            .ofm_i   (ofm_x[0][h+1]),
            .en_i_o  (en_i_x[h][1]),
            .clr_i_o (clr_i_x[h][1]),
            .ifm_o   (ifm_x[h][1]),
            .en_w_o  (en_w_x[0][h+1]),
            .wght_o  (wght_x[0][h+1]),
            .en_o_o  (en_o_x[0][h]),
            .clr_o_o (clr_o_x[0][h]),
            .ofm_o   (ofm_x[0][h])
        );

        for (w = 1; w < WIDTH; w++) begin : g_col
            pe_inner #(
                .IWIDTH (IWIDTH),
                .OWIDTH (OWIDTH)
            ) u_pe_inner (
                .clk     (clk),
                .rst_i   (rst_i),
                .en_i_i  (en_i_x[h][w]),
                .clr_i_i (clr_i_x[h][w]),
                .ifm_i   (ifm_x[h][w]),
                .en_w_i  (en_w_x[w][h]),
                .wght_i  (wght_x[w][h]),
                .en_o_i  (en_o_x[w][h+1]),
                .clr_o_i (clr_o_x[w][h+1]),
                .ofm_i   (ofm_x[w][h+1]),
                .en_i_o  (en_i_x[h][w+1]),
                .clr_i_o (clr_i_x[h][w+1]),
                .ifm_o   (ifm_x[h][w+1]),
                .en_w_o  (en_w_x[w][h+1]),
                .wght_o  (wght_x[w][h+1]),
                .en_o_o  (en_o_x[w][h]),
                .clr_o_o (clr_o_x[w][h]),
                .ofm_o   (ofm_x[w][h])
            );
        end
    end

endmodule

`default_nettype wire

/* logic/array_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module array_ctrl #(
    parameter int HEIGHT = sa_pkg::DEF_HEIGHT,
    parameter int WIDTH  = sa_pkg::DEF_WIDTH,
    parameter int LEN_W  = sa_pkg::DEF_LEN_W
) (
    input  logic              clk,
    input  logic              rst_i,
    input  logic              start_i,
    input  logic [LEN_W-1:0]  len_i,
    input  logic              wght_vld_i,
    input  logic              ifm_vld_i,
    output logic [WIDTH-1:0]  en_w_o,
    output logic [WIDTH-1:0]  clr_o_o,
    output logic [WIDTH-1:0]  en_o_o,
    output logic [HEIGHT-1:0] en_i_o,
    output logic [HEIGHT-1:0] clr_i_o,
    output logic              busy_o,
    output logic              done_o
);

    localparam int CNT_W = $clog2(HEIGHT + WIDTH + 1);
    localparam int ROW_W = $clog2(HEIGHT + 1);

    sa_pkg::ctrl_state_e state_q;
    logic [ROW_W-1:0]    row_cnt_q;
    logic [LEN_W-1:0]    vec_cnt_q;
    logic [LEN_W-1:0]    len_q;
    logic [CNT_W-1:0]    cyc_cnt_q;
    logic                clr_q;
    logic                done_q;
    logic                w_take;
    logic                i_take;

    // Strobes count only in their own state
    assign w_take = (state_q == sa_pkg::S_LOAD_W) && wght_vld_i;
    assign i_take = (state_q == sa_pkg::S_STREAM) && ifm_vld_i;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q   <= sa_pkg::S_IDLE;
            row_cnt_q <= '0;
            vec_cnt_q <= '0;
            len_q     <= '0;
            cyc_cnt_q <= '0;
            clr_q     <= 1'b0;
            done_q    <= 1'b0;
        end else begin
            clr_q  <= 1'b0;
            done_q <= 1'b0;
            case (state_q)
                sa_pkg::S_IDLE: begin
                    if (start_i) begin
                        state_q   <= sa_pkg::S_LOAD_W;
                        len_q     <= len_i;
                        row_cnt_q <= '0;
                        vec_cnt_q <= '0;
                        clr_q     <= 1'b1;      // Clears acc and output chain
                    end
                end
                sa_pkg::S_LOAD_W: begin
                    if (w_take) begin
                        if (row_cnt_q == ROW_W'(HEIGHT - 1)) state_q <= sa_pkg::S_STREAM;
                        else row_cnt_q <= row_cnt_q + 1'b1;
                    end
                end
                sa_pkg::S_STREAM: begin
                    if (i_take) begin
                        if (vec_cnt_q == len_q - 1'b1) begin
                            state_q   <= sa_pkg::S_DRAIN;
                            cyc_cnt_q <= '0;
                        end else begin
                            vec_cnt_q <= vec_cnt_q + 1'b1;
                        end
                    end
                end
                sa_pkg::S_DRAIN: begin
                    if (cyc_cnt_q == CNT_W'(HEIGHT + WIDTH - 1)) begin
                        state_q   <= sa_pkg::S_SUM;
                        cyc_cnt_q <= '0;
                    end else begin
                        cyc_cnt_q <= cyc_cnt_q + 1'b1;
                    end
                end
                sa_pkg::S_SUM: begin
                    if (cyc_cnt_q == CNT_W'(HEIGHT - 1)) begin
                        state_q <= sa_pkg::S_IDLE;
                        done_q  <= 1'b1;
                    end else begin
                        cyc_cnt_q <= cyc_cnt_q + 1'b1;
                    end
                end
                default: state_q <= sa_pkg::S_IDLE;
            endcase
        end
    end

    assign en_w_o  = {WIDTH{w_take}};
    assign en_i_o  = {HEIGHT{i_take}};              // Skew is added inside the array
    assign clr_i_o = {HEIGHT{clr_q}};
    assign clr_o_o = {WIDTH{clr_q}};
    assign en_o_o  = {WIDTH{state_q == sa_pkg::S_SUM}};
    assign busy_o  = (state_q != sa_pkg::S_IDLE);
    assign done_o  = done_q;

endmodule

`default_nettype wire

/* logic/pe_border.sv */
`timescale 1ns/1ps
`default_nettype none

module pe_border #(
    parameter int ROW_DELAY = 0,
    parameter int IWIDTH    = sa_pkg::DEF_IWIDTH,
    parameter int OWIDTH    = sa_pkg::DEF_OWIDTH
) (
    input  logic                     clk,
    input  logic                     rst_i,
    input  logic                     en_i_i,
    input  logic                     clr_i_i,
    input  logic signed [IWIDTH-1:0] ifm_i,
    input  logic                     en_w_i,
    input  logic signed [IWIDTH-1:0] wght_i,
    input  logic                     en_o_i,
    input  logic                     clr_o_i,
    input  logic signed [OWIDTH-1:0] ofm_i,
    output logic                     en_i_o,
    output logic                     clr_i_o,
    output logic signed [IWIDTH-1:0] ifm_o,
    output logic                     en_w_o,
    output logic signed [IWIDTH-1:0] wght_o,
    output logic                     en_o_o,
    output logic                     clr_o_o,
    output logic signed [OWIDTH-1:0] ofm_o
);

    logic [ROW_DELAY:0]         en_q;
    logic [ROW_DELAY:0]         clr_q;
    logic signed [IWIDTH-1:0]   ifm_q [ROW_DELAY:0];
    logic                       en_mac;
    logic                       clr_mac;
    logic signed [IWIDTH-1:0]   ifm_mac;
    logic signed [IWIDTH-1:0]   wght_q;
    logic signed [OWIDTH-1:0]   acc_q;
    logic signed [OWIDTH-1:0]   ofm_q;
    logic signed [2*IWIDTH-1:0] prod;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            en_q  <= '0;
            clr_q <= '0;
            for (int k = 0; k <= ROW_DELAY; k++) ifm_q[k] <= '0;
        end else begin
            en_q[0]  <= en_i_i;
            clr_q[0] <= clr_i_i;
            ifm_q[0] <= ifm_i;
            for (int k = 1; k <= ROW_DELAY; k++) begin
                en_q[k]  <= en_q[k-1];
                clr_q[k] <= clr_q[k-1];
                ifm_q[k] <= ifm_q[k-1];
            end
        end
    end

    // MAC taps the line one stage before the forwarded output
    if (ROW_DELAY == 0) begin : g_no_dly
        assign en_mac  = en_i_i;
        assign clr_mac = clr_i_i;
        assign ifm_mac = ifm_i;
    end else begin : g_dly
        assign en_mac  = en_q[ROW_DELAY-1];
        assign clr_mac = clr_q[ROW_DELAY-1];
        assign ifm_mac = ifm_q[ROW_DELAY-1];
    end

    assign prod = ifm_mac * wght_q;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            wght_q <= '0;
            acc_q  <= '0;
            ofm_q  <= '0;
        end else begin
            if (en_w_i) wght_q <= wght_i;            // Old weight moves to the row below
            if (clr_mac) acc_q <= '0;
            else if (en_mac) acc_q <= acc_q + OWIDTH'(prod);
            if (clr_o_i) ofm_q <= '0;
            else if (en_o_i) ofm_q <= ofm_i + acc_q;
        end
    end

    assign en_i_o  = en_q[ROW_DELAY];
    assign clr_i_o = clr_q[ROW_DELAY];
    assign ifm_o   = ifm_q[ROW_DELAY];
    assign en_w_o  = en_w_i;
    assign wght_o  = wght_q;
    assign en_o_o  = en_o_i;                         // Whole column sums in lockstep
    assign clr_o_o = clr_o_i;
    assign ofm_o   = ofm_q;

endmodule

`default_nettype wire

/* logic/pe_inner.sv */
`timescale 1ns/1ps
`default_nettype none

module pe_inner #(
    parameter int IWIDTH = sa_pkg::DEF_IWIDTH,
    parameter int OWIDTH = sa_pkg::DEF_OWIDTH
) (
    input  logic                     clk,
    input  logic                     rst_i,
    input  logic                     en_i_i,
    input  logic                     clr_i_i,
    input  logic signed [IWIDTH-1:0] ifm_i,
    input  logic                     en_w_i,
    input  logic signed [IWIDTH-1:0] wght_i,
    input  logic                     en_o_i,
    input  logic                     clr_o_i,
    input  logic signed [OWIDTH-1:0] ofm_i,
    output logic                     en_i_o,
    output logic                     clr_i_o,
    output logic signed [IWIDTH-1:0] ifm_o,
    output logic                     en_w_o,
    output logic signed [IWIDTH-1:0] wght_o,
    output logic                     en_o_o,
    output logic                     clr_o_o,
    output logic signed [OWIDTH-1:0] ofm_o
);

    logic                       en_i_q;
    logic                       clr_i_q;
    logic signed [IWIDTH-1:0]   ifm_q;
    logic signed [IWIDTH-1:0]   wght_q;
    logic signed [OWIDTH-1:0]   acc_q;
    logic signed [OWIDTH-1:0]   ofm_q;
    logic signed [2*IWIDTH-1:0] prod;

    assign prod = ifm_i * wght_q;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            en_i_q  <= 1'b0;
            clr_i_q <= 1'b0;
            ifm_q   <= '0;
            wght_q  <= '0;
            acc_q   <= '0;
            ofm_q   <= '0;
        end else begin
            en_i_q  <= en_i_i;                       // One stage per column
            clr_i_q <= clr_i_i;
            ifm_q   <= ifm_i;
            if (en_w_i) wght_q <= wght_i;
            if (clr_i_i) acc_q <= '0;
            else if (en_i_i) acc_q <= acc_q + OWIDTH'(prod);
            if (clr_o_i) ofm_q <= '0;
            else if (en_o_i) ofm_q <= ofm_i + acc_q; // Partial sum from below
        end
    end

    assign en_i_o  = en_i_q;
    assign clr_i_o = clr_i_q;
    assign ifm_o   = ifm_q;
    assign en_w_o  = en_w_i;
    assign wght_o  = wght_q;
    assign en_o_o  = en_o_i;
    assign clr_o_o = clr_o_i;
    assign ofm_o   = ofm_q;

endmodule

`default_nettype wire

/* logic/sa_pkg.sv */
`default_nettype none

package sa_pkg;

    parameter int DEF_IWIDTH = 8;   // Signed input and weight width
    parameter int DEF_OWIDTH = 24;  // Signed accumulator width
    parameter int DEF_HEIGHT = 8;
    parameter int DEF_WIDTH  = 8;
    parameter int DEF_LEN_W  = 8;   // Vector count width

    typedef enum logic [2:0] {
        S_IDLE,
        S_LOAD_W,                   // Shifting weight rows down
        S_STREAM,                   // Accepting input vectors
        S_DRAIN,                    // Wavefront leaves the grid
        S_SUM                       // Column sums move up
    } ctrl_state_e;

endpackage

`default_nettype wire

/* logic/sa_top.sv */
`timescale 1ns/1ps
`default_nettype none

module sa_top #(
    parameter int HEIGHT = 4,
    parameter int WIDTH  = 4,
    parameter int IWIDTH = sa_pkg::DEF_IWIDTH,
    parameter int OWIDTH = sa_pkg::DEF_OWIDTH,
    parameter int LEN_W  = sa_pkg::DEF_LEN_W
) (
    input  logic                     clk,
    input  logic                     rst_i,
    input  logic                     start_i,
    input  logic [LEN_W-1:0]         len_i,
    input  logic                     wght_vld_i,
    input  logic signed [IWIDTH-1:0] wght_i [WIDTH-1:0],
    input  logic                     ifm_vld_i,
    input  logic signed [IWIDTH-1:0] ifm_i  [HEIGHT-1:0],
    output logic                     busy_o,
    output logic                     done_o,
    output logic signed [OWIDTH-1:0] ofm_o  [WIDTH-1:0]
);

    logic [WIDTH-1:0]  en_w;
    logic [WIDTH-1:0]  en_o;
    logic [WIDTH-1:0]  clr_o;
    logic [HEIGHT-1:0] en_i;
    logic [HEIGHT-1:0] clr_i;

    array_ctrl #(
        .HEIGHT (HEIGHT),
        .WIDTH  (WIDTH),
        .LEN_W  (LEN_W)
    ) u_array_ctrl (
        .clk        (clk),
        .rst_i      (rst_i),
        .start_i    (start_i),
        .len_i      (len_i),
        .wght_vld_i (wght_vld_i),
        .ifm_vld_i  (ifm_vld_i),
        .en_w_o     (en_w),
        .clr_o_o    (clr_o),
        .en_o_o     (en_o),
        .en_i_o     (en_i),
        .clr_i_o    (clr_i),
        .busy_o     (busy_o),
        .done_o     (done_o)
    );

    array_8 #(
        .HEIGHT (HEIGHT),
        .WIDTH  (WIDTH),
        .IWIDTH (IWIDTH),
        .OWIDTH (OWIDTH)
    ) u_array_8 (
        .clk     (clk),
        .rst_i   (rst_i),
        .en_i_i  (en_i),
        .clr_i_i (clr_i),
        .en_w_i  (en_w),
        .en_o_i  (en_o),
        .clr_o_i (clr_o),
        .ifm_i   (ifm_i),
        .wght_i  (wght_i),
        .ofm_o   (ofm_o)
    );

endmodule

`default_nettype wire

/* testbench/sa_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module sa_checker #(
    parameter int HEIGHT = 4,
    parameter int WIDTH  = 4,
    parameter int IWIDTH = sa_pkg::DEF_IWIDTH,
    parameter int OWIDTH = sa_pkg::DEF_OWIDTH,
    parameter int LEN_W  = sa_pkg::DEF_LEN_W
) (
    input  logic                     clk,
    input  logic                     rst_i,
    input  logic                     start_i,
    input  logic [LEN_W-1:0]         len_i,
    input  logic                     wght_vld_i,
    input  logic signed [IWIDTH-1:0] wght_i [WIDTH-1:0],
    input  logic                     ifm_vld_i,
    input  logic signed [IWIDTH-1:0] ifm_i  [HEIGHT-1:0],
    input  logic                     busy_i,
    input  logic                     done_i,
    input  logic signed [OWIDTH-1:0] ofm_i  [WIDTH-1:0],
    input  int                       test_idx_i,
    output int                       err_cnt_o,
    output int                       pass_cnt_o,
    output int                       fail_cnt_o
);

    localparam int LATENCY = 2 * HEIGHT + WIDTH + 1;    // Last ifm strobe to done_o

    sa_pkg::ctrl_state_e      mstate = sa_pkg::S_IDLE;  // S_DRAIN covers drain and sum
    int                       wrow [HEIGHT][WIDTH];
    longint                   exp_sum [WIDTH];
    int                       rows_seen;
    int                       vecs_seen;
    int                       len_q;
    int                       wait_cnt;
    int                       job_err;
    int                       err_cnt  = 0;
    int                       pass_cnt = 0;
    int                       fail_cnt = 0;
    logic signed [OWIDTH-1:0] exp_v;

    assign err_cnt_o  = err_cnt;
    assign pass_cnt_o = pass_cnt;
    assign fail_cnt_o = fail_cnt;

    task automatic report(input string name, input longint exp_val, input longint act_val);
        $display("FAIL t=%0t %s expected %0d got %0d", $time, name, exp_val, act_val);
        err_cnt++;
        job_err++;
    endtask

    task automatic check_ctrl(input logic busy_exp, input logic done_exp);
        if (busy_i !== busy_exp) report("busy_o", busy_exp, busy_i);
        if (done_i !== done_exp) report("done_o", done_exp, done_i);
    endtask

    task automatic begin_job();
        mstate    = sa_pkg::S_LOAD_W;
        len_q     = int'(len_i);
        rows_seen = 0;
        vecs_seen = 0;
        job_err   = 0;
        for (int w = 0; w < WIDTH; w++) exp_sum[w] = 0;
    endtask

    task automatic finish_job();
        check_ctrl(1'b0, 1'b1);
        for (int w = 0; w < WIDTH; w++) begin
            exp_v = exp_sum[w][OWIDTH-1:0];             // Two's complement wrap
            if (ofm_i[w] !== exp_v) report($sformatf("ofm_o[%0d]", w), exp_v, ofm_i[w]);
        end
        if (job_err == 0) begin
            pass_cnt++;
            $display("PASS test %0d: %0d vectors, done_o %0d cycles after last strobe",
                     test_idx_i, len_q, LATENCY);
        end else begin
            fail_cnt++;
            $display("Test %0d failed with %0d errors", test_idx_i, job_err);
        end
        mstate = sa_pkg::S_IDLE;
        if (start_i) begin_job();                       // Start in the done cycle is legal
    endtask

    always @(posedge clk) begin
        if (rst_i) begin
            if (mstate != sa_pkg::S_IDLE)
                $display("Reset dropped test %0d during %s", test_idx_i, mstate.name());
            mstate = sa_pkg::S_IDLE;
        end else begin
            case (mstate)
                sa_pkg::S_IDLE: begin
                    check_ctrl(1'b0, 1'b0);
                    if (start_i) begin_job();
                end
                sa_pkg::S_LOAD_W: begin
                    check_ctrl(1'b1, 1'b0);
                    if (wght_vld_i) begin
                        for (int w = 0; w < WIDTH; w++) begin
                            for (int h = HEIGHT - 1; h > 0; h--) wrow[h][w] = wrow[h-1][w];
                            wrow[0][w] = int'(wght_i[w]); // Last strobe ends in row 0
                        end
                        rows_seen++;
                        if (rows_seen == HEIGHT) mstate = sa_pkg::S_STREAM;
                    end
                end
                sa_pkg::S_STREAM: begin
                    check_ctrl(1'b1, 1'b0);
                    if (ifm_vld_i) begin
                        for (int w = 0; w < WIDTH; w++) begin
                            for (int h = 0; h < HEIGHT; h++)
                                exp_sum[w] += longint'(ifm_i[h]) * wrow[h][w];
                        end
                        vecs_seen++;
                        if (vecs_seen == len_q) begin
                            mstate   = sa_pkg::S_DRAIN;
                            wait_cnt = 0;
                        end
                    end
                end
                default: begin
                    wait_cnt++;
                    if (wait_cnt < LATENCY) check_ctrl(1'b1, 1'b0);
                    else finish_job();
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* testbench/tb_sa_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_sa_top;

    localparam int HEIGHT = 4;
    localparam int WIDTH  = 4;
    localparam int IWIDTH = 8;
    localparam int OWIDTH = 24;
    localparam int LEN_W  = 8;
    localparam int NJOB   = 8;

    logic                     clk;
    logic                     rst_i;
    logic                     start_i;
    logic [LEN_W-1:0]         len_i;
    logic                     wght_vld_i;
    logic signed [IWIDTH-1:0] wght_i [WIDTH-1:0];
    logic                     ifm_vld_i;
    logic signed [IWIDTH-1:0] ifm_i  [HEIGHT-1:0];
    logic                     busy_o;
    logic                     done_o;
    logic signed [OWIDTH-1:0] ofm_o  [WIDTH-1:0];
    int                       test_idx;
    int                       err_cnt;
    int                       pass_cnt;
    int                       fail_cnt;
    bit                       timed_out;
    logic [31:0]              lcg_state;

    // Data mode 0 random, 1 mixed extremes, 2 all most negative
    int    len_tab   [NJOB] = '{1, 12, 5, 3, 6, 8, 200, 9};
    int    gap_tab   [NJOB] = '{0, 1, 0, 1, 1, 0, 0, 1};
    bit    stray_tab [NJOB] = '{0, 0, 0, 0, 1, 0, 0, 0};
    int    abort_tab [NJOB] = '{0, 0, 0, 0, 0, 4, 0, 0};  // Reset after this many vectors
    int    data_tab  [NJOB] = '{0, 0, 0, 0, 0, 0, 2, 1};
    string label_tab [NJOB] = '{"single vector", "gapped stream", "back to back first",
                                "back to back second", "stray start and strobes",
                                "reset mid job", "wraparound", "extreme values"};

    sa_top #(
        .HEIGHT (HEIGHT),
        .WIDTH  (WIDTH),
        .IWIDTH (IWIDTH),
        .OWIDTH (OWIDTH),
        .LEN_W  (LEN_W)
    ) i_dut (
        .clk        (clk),
        .rst_i      (rst_i),
        .start_i    (start_i),
        .len_i      (len_i),
        .wght_vld_i (wght_vld_i),
        .wght_i     (wght_i),
        .ifm_vld_i  (ifm_vld_i),
        .ifm_i      (ifm_i),
        .busy_o     (busy_o),
        .done_o     (done_o),
        .ofm_o      (ofm_o)
    );

    sa_checker #(
        .HEIGHT (HEIGHT),
        .WIDTH  (WIDTH),
        .IWIDTH (IWIDTH),
        .OWIDTH (OWIDTH),
        .LEN_W  (LEN_W)
    ) i_checker (
        .clk        (clk),
        .rst_i      (rst_i),
        .start_i    (start_i),
        .len_i      (len_i),
        .wght_vld_i (wght_vld_i),
        .wght_i     (wght_i),
        .ifm_vld_i  (ifm_vld_i),
        .ifm_i      (ifm_i),
        .busy_i     (busy_o),
        .done_i     (done_o),
        .ofm_i      (ofm_o),
        .test_idx_i (test_idx),
        .err_cnt_o  (err_cnt),
        .pass_cnt_o (pass_cnt),
        .fail_cnt_o (fail_cnt)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic logic signed [IWIDTH-1:0] pick_value(input int mode);
        logic [31:0] r;
        r = lcg_next();
        if (mode == 2) return {1'b1, {(IWIDTH-1){1'b0}}};
        if (mode == 1) return r[20] ? {1'b1, {(IWIDTH-1){1'b0}}} : {1'b0, {(IWIDTH-1){1'b1}}};
        return r[16 +: IWIDTH];                          // Upper LCG bits
    endfunction

    task automatic drive(input bit start, input bit wvld, input bit ivld, input int mode);
        @(posedge clk);
        start_i    <= start;
        wght_vld_i <= wvld;
        ifm_vld_i  <= ivld;
        for (int w = 0; w < WIDTH; w++) begin
            if (wvld) wght_i[w] <= pick_value(mode);
        end
        for (int h = 0; h < HEIGHT; h++) begin
            if (ivld) ifm_i[h] <= pick_value(mode);
        end
    endtask

    task automatic reset_dut(input int cycles);
        @(posedge clk);
        start_i    <= 1'b0;
        wght_vld_i <= 1'b0;
        ifm_vld_i  <= 1'b0;
        rst_i      <= 1'b1;
        repeat (cycles) @(posedge clk);
        rst_i <= 1'b0;
    endtask

    task automatic wait_rise(input bit want_done, input int limit);
        int n;
        bit seen;
        n    = 0;
        seen = 1'b0;
        while (!seen && n < limit) begin
            @(posedge clk);
            seen = want_done ? (done_o === 1'b1) : (busy_o === 1'b1);
            n++;
        end
        if (!seen) begin
            $display("Timeout in test %0d (%s): %s did not rise within %0d cycles",
                     test_idx, label_tab[test_idx], want_done ? "done_o" : "busy_o", limit);
            timed_out = 1'b1;
        end
    endtask

    task automatic run_job(input int idx, input int abort_at);
        int len;
        int mode;
        int gap;
        len  = len_tab[idx];
        mode = data_tab[idx];
        if (stray_tab[idx]) drive(1'b0, 1'b1, 1'b1, mode);   // Strobes while idle
        drive(1'b1, 1'b0, 1'b0, mode);
        len_i <= LEN_W'(len);
        drive(1'b0, 1'b0, 1'b0, mode);
        wait_rise(1'b0, 4);
        if (timed_out) return;
        for (int r = 0; r < HEIGHT; r++) begin
            drive(1'b0, 1'b1, 1'b0, mode);
            if (stray_tab[idx] && r == 1) drive(1'b1, 1'b0, 1'b1, mode);
        end
        for (int v = 0; v < len; v++) begin
            gap = (gap_tab[idx] != 0) ? int'(lcg_next() % 4) : 0;
            repeat (gap) drive(1'b0, 1'b0, 1'b0, mode);
            drive(1'b0, 1'b0, 1'b1, mode);
            if (v + 1 == abort_at) begin
                reset_dut(10);
                return;
            end
            if (stray_tab[idx] && v == 0) drive(1'b1, 1'b1, 1'b0, mode);
        end
        drive(1'b0, 1'b0, 1'b0, mode);
        if (stray_tab[idx]) begin
            drive(1'b1, 1'b1, 1'b1, mode);                    // Lands in drain
            drive(1'b0, 1'b0, 1'b0, mode);
        end
        wait_rise(1'b1, 16 * len + 64);
    endtask

    initial begin
        rst_i      <= 1'b1;
        start_i    <= 1'b0;
        len_i      <= '0;
        wght_vld_i <= 1'b0;
        ifm_vld_i  <= 1'b0;
        for (int w = 0; w < WIDTH; w++) wght_i[w] <= '0;
        for (int h = 0; h < HEIGHT; h++) ifm_i[h] <= '0;
        test_idx   <= 0;
        lcg_state = 32'd67;
        timed_out = 1'b0;
        repeat (10) @(posedge clk);
        rst_i <= 1'b0;
        for (int i = 0; i < NJOB && !timed_out; i++) begin
            test_idx <= i;
            if (abort_tab[i] > 0) begin
                run_job(i, abort_tab[i]);
                repeat (10) drive(1'b0, 1'b0, 1'b0, 0);       // busy_o and done_o stay low
            end
            if (!timed_out) run_job(i, 0);
        end
        repeat (5) @(posedge clk);
        $display("Tests: %0d passed, %0d failed, %0d errors", pass_cnt, fail_cnt, err_cnt);
        if (!timed_out && err_cnt == 0 && fail_cnt == 0 && pass_cnt == NJOB) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
